/* list.f */
src/scedma_sfr_pkg.sv
src/scedma_pkg.sv
src/scedma_sfr.sv
src/scedma_segmap.sv
src/scedma_chnl.sv
src/scedma.sv
bench/scedma_sva.sv
bench/scedma_tb.sv

/* Makefile */
# Verilator build and run for the scedma testbench

VERILATOR ?= verilator
TOP       ?= scedma_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  ?= Done: errors found
PASS_MSG  ?= Done: no errors

SIM = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	$(SIM) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi; \
	if [ $$status -ne 0 ] || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation did not finish cleanly"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/scedma_tb.sv */
// scedma testbench
// drives the register port, models the segment memory with one cycle
// read latency and checks every write against a reference built from
// the segment wrap and data rules

`timescale 1ns/1ps

module scedma_tb
    import scedma_pkg::*, scedma_sfr_pkg::*;
();

    // register test, copy, xor, fill, zero length, bad segment, busy start
    localparam int NTESTS = 7;

    logic       clk = 1'b0;
    logic       reset;
    logic       wr;
    logic       rd;
    sfr_adr_t   addr;
    dat_t       wdata;
    dat_t       rdata;
    chnlreq_t   rpreq;
    chnlreq_t   wpreq;
    chnlres_t   rpres = '0;
    logic       intr;
    logic [1:0] err;

    // memory side read pipe
    chnlreq_t   rd_q = '0;
    chnlreq_t   exp_w;
    chnlreq_t   exp_q[$];
    int         cyc;
    int         limit;
    int         nerr;
    int         nchecks;
    int         start_cyc;
    int         first_req_cyc;
    int         last_wr_cyc;
    int         intr_cyc;
    int         nreads;
    int         nwrites;
    int         nintr;
    int         len[4];
    string      test_name;

    always #20 clk = ~clk;

    scedma scedma_i (
        .clk, .reset, .wr, .rd, .addr, .wdata, .rdata,
        .rpreq, .rpres, .wpreq, .intr, .err
    );

    // memory contents depend on every address bit
    function automatic dat_t mem_word(adr_t a);
        return {~a, 8'hc3, a};
    endfunction

    function automatic int seg_base(int s);
        case (s)
            1: return 'h100;
            2: return 'h200;
            3: return 'h280;
            default: return 0;
        endcase
    endfunction

    // segment size in words
    function automatic int seg_size(int s);
        return (s < 2) ? 256 : ((s == 2) ? 128 : 64);
    endfunction

    // expected write of word i, pointers wrap inside their segment
    function automatic chnlreq_t ref_word(chnl_op_e op, int rseg, int wseg,
                                          int rp, int wp, int i, dat_t m);
        chnlreq_t r;
        adr_t     ra;
        ra      = adr_t'(seg_base(rseg) + (rp + i) % seg_size(rseg));
        r.valid = 1'b1;
        r.addr  = adr_t'(seg_base(wseg) + (wp + i) % seg_size(wseg));
        case (op)
            OP_XOR:  r.wdata = mem_word(ra) ^ m;
            OP_FILL: r.wdata = m;
            default: r.wdata = mem_word(ra);
        endcase
        return r;
    endfunction

    task automatic check_adr(string what, adr_t exp, adr_t act);
        nchecks++;
        if (exp !== act) begin
            nerr++;
            $display("ERR %s %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_dat(string what, dat_t exp, dat_t act);
        nchecks++;
        if (exp !== act) begin
            nerr++;
            $display("ERR %s %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_reg(string what, dat_t exp, dat_t act);
        nchecks++;
        if (exp !== act) begin
            nerr++;
            $display("ERR %s %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    // sticky error output of the top level
    task automatic check_err(string what, logic [1:0] exp, logic [1:0] act);
        nchecks++;
        if (exp !== act) begin
            nerr++;
            $display("ERR %s %s: expected %b, actual %b", test_name, what, exp, act);
        end
    endtask

    // cycle numbers and event counts
    task automatic check_count(string what, int exp, int act);
        nchecks++;
        if (exp != act) begin
            nerr++;
            $display("ERR %s %s: expected %0d, actual %0d", test_name, what, exp, act);
        end
    endtask

    task automatic reg_write(sfr_adr_t a, dat_t d);
        @(negedge clk);
        wr    = 1'b1;
        addr  = a;
        wdata = d;
        @(negedge clk);
        wr    = 1'b0;
    endtask

    // rdata is registered on the edge that sees rd
    task automatic reg_read(sfr_adr_t a, output dat_t d);
        @(negedge clk);
        rd   = 1'b1;
        addr = a;
        @(negedge clk);
        rd   = 1'b0;
        d    = rdata;
    endtask

    task automatic write_read(string what, sfr_adr_t a, dat_t d);
        dat_t got;
        reg_write(a, d);
        reg_read(a, got);
        check_reg(what, d, got);
    endtask

    // key write, cyc now is the edge that samples it
    task automatic start_chnl();
        @(negedge clk);
        wr            = 1'b1;
        addr          = A_START;
        wdata         = dat_t'(START_KEY);
        start_cyc     = cyc;
        first_req_cyc = -1;
        nreads        = 0;
        nwrites       = 0;
        @(negedge clk);
        wr            = 1'b0;
    endtask

    task automatic run_xfer(string name, chnl_op_e op, int rseg, int wseg,
                            int rp, int wp, int n, dat_t m, bit restart);
        int n0;
        test_name = name;
        reg_write(A_OPT, dat_t'(op));
        reg_write(A_SEGID, dat_t'(rseg * 256 + wseg));
        reg_write(A_RPSTART, dat_t'(rp));
        reg_write(A_WPSTART, dat_t'(wp));
        reg_write(A_TRANSIZE, dat_t'(n));
        reg_write(A_MASK, m);
        for (int i = 0; i < n; i++)
            exp_q.push_back(ref_word(op, rseg, wseg, rp, wp, i, m));
        n0 = nintr;
        start_chnl();
        if (restart) begin
            // second key once the channel is running
            while (first_req_cyc < 0)
                @(negedge clk);
            reg_write(A_START, dat_t'(START_KEY));
        end
        while (nintr == n0)
            @(negedge clk);
        check_count("writes", n, nwrites);
        check_count("reads", (op == OP_FILL) ? 0 : n, nreads);
        check_count("writes left over", 0, exp_q.size());
        if (n == 0) begin
            check_count("intr cycle", start_cyc + 3, intr_cyc);
        end else begin
            check_count("first request cycle", start_cyc + 3, first_req_cyc);
            check_count("intr cycle", last_wr_cyc + 1, intr_cyc);
        end
    endtask

    // memory answers one cycle after each read
    always @(posedge clk)
        rd_q <= rpreq;

    always @(negedge clk) begin
        rpres.valid = rd_q.valid;
        rpres.rdata = mem_word(rd_q.addr);
    end

    // event monitor and run limit
    always @(posedge clk) begin
        if (!reset) begin
            if ((rpreq.valid || wpreq.valid) && first_req_cyc < 0)
                first_req_cyc = cyc;
            if (rpreq.valid)
                nreads++;
            if (wpreq.valid) begin
                nwrites++;
                last_wr_cyc = cyc;
            end
            if (intr) begin
                nintr++;
                intr_cyc = cyc;
            end
        end
        cyc++;
        if (cyc > limit) begin
            $display("timeout: run went past %0d cycles", limit);
            $display("Done: errors found");
            $finish;
        end
    end

    // writes against the expected queue, in order
    always @(posedge clk) begin
        if (!reset && wpreq.valid) begin
            if (exp_q.size() == 0) begin
                nerr++;
                $display("unexpected write to address %h in test %s", wpreq.addr, test_name);
            end else begin
                exp_w = exp_q.pop_front();
                check_adr("write address", exp_w.addr, wpreq.addr);
                check_dat("write data", exp_w.wdata, wpreq.wdata);
            end
        end
    end

    initial begin
        dat_t got;
        void'($urandom(32'hcc4f));
        reset         = 1'b1;
        wr            = 1'b0;
        rd            = 1'b0;
        addr          = '0;
        wdata         = '0;
        first_req_cyc = -1;
        // copy, xor, fill and busy lengths
        foreach (len[k])
            len[k] = 8 + int'($urandom_range(40));
        limit = 40 * NTESTS;
        foreach (len[k])
            limit += len[k];
        repeat (5) @(negedge clk);
        reset = 1'b0;

        test_name = "registers";
        write_read("opt", A_OPT, 32'h2);
        write_read("segid", A_SEGID, $urandom() & 32'hffff);
        write_read("rpstart", A_RPSTART, $urandom() & 32'h3ff);
        write_read("wpstart", A_WPSTART, $urandom() & 32'h3ff);
        write_read("transize", A_TRANSIZE, $urandom() & 32'h3ff);
        write_read("mask", A_MASK, $urandom());
        reg_read(A_STATUS, got);
        check_reg("status idle", 32'h0, got);

        // pointers just below the segment end so both sides wrap
        run_xfer("copy", OP_COPY, 2, 3, 120 + int'($urandom_range(7)),
                 56 + int'($urandom_range(7)), len[0], $urandom(), 1'b0);
        run_xfer("xor", OP_XOR, 0, 1, 250 + int'($urandom_range(5)),
                 240 + int'($urandom_range(15)), len[1], $urandom(), 1'b0);
        run_xfer("fill", OP_FILL, 0, 3, 0, 60 + int'($urandom_range(3)),
                 len[2], $urandom(), 1'b0);
        run_xfer("zero length", OP_COPY, 0, 1, 5, 9, 0, '0, 1'b0);

        test_name = "segment error";
        // nonzero length so a wrong go would show up as requests
        reg_write(A_TRANSIZE, 32'h10);
        reg_write(A_SEGID, 32'h0501);
        start_chnl();
        while (err[1] == 1'b0)
            @(negedge clk);
        // past the cycle a first request would have shown
        repeat (3) @(negedge clk);
        check_count("requests", 0, nreads + nwrites);
        reg_read(A_STATUS, got);
        check_reg("status seg", 32'h4, got);
        check_err("err seg", 2'b10, err);

        run_xfer("start while busy", OP_COPY, 1, 2, int'($urandom_range(255)),
                 int'($urandom_range(127)), len[3], '0, 1'b1);
        reg_read(A_STATUS, got);
        check_reg("status both errors", 32'h6, got);
        check_err("err both", 2'b11, err);
        reg_write(A_STATUS, 32'h0);
        reg_read(A_STATUS, got);
        check_reg("status cleared", 32'h0, got);
        check_err("err cleared", 2'b00, err);

        $display("checks %0d, errors %0d", nchecks, nerr);
        if (nerr == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

/* bench/scedma_sva.sv */
// scedma channel assertions
// bound into the channel engine, covers request timing and the
// shape of the done pulse

`timescale 1ns/1ps

module scedma_sva
    import scedma_pkg::*;
(
    input logic     clk,
    input logic     reset,
    input chnlreq_t rpreq,
    input chnlreq_t wpreq,
    input logic     busy,
    input logic     done
);

    // requests only while the channel runs
    req_in_busy: assert property (@(posedge clk) disable iff (reset)
        (rpreq.valid || wpreq.valid) |-> busy)
        else $error("request valid while the channel is idle");

    // every read is answered and written one cycle later
    wr_after_rd: assert property (@(posedge clk) disable iff (reset)
        rpreq.valid |=> wpreq.valid)
        else $error("no write one cycle after a read");

    // single cycle pulse
    done_pulse: assert property (@(posedge clk) disable iff (reset)
        done |=> !done)
        else $error("done held longer than one cycle");

endmodule

bind scedma_chnl scedma_sva sva_i (
    .clk, .reset, .rpreq, .wpreq, .busy, .done
);

/* src/scedma.sv */
// scedma top level
// register bank, segment resolve stage and channel engine in a row;
// the segment memory sits outside on the rpreq/rpres and wpreq ports

`timescale 1ns/1ps

module scedma
    import scedma_pkg::*, scedma_sfr_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       wr,
    input  logic       rd,
    input  sfr_adr_t   addr,
    input  dat_t       wdata,
    output dat_t       rdata,
    output chnlreq_t   rpreq,
    input  chnlres_t   rpres,
    output chnlreq_t   wpreq,
    output logic       intr,
    output logic [1:0] err
);

    // stage 1 to 2
    logic     start;
    chnl_op_e op;
    segid_t   rpsegid;
    segid_t   wpsegid;
    tcnt_t    rpstart;
    tcnt_t    wpstart;
    tcnt_t    transize;
    dat_t     mask;
    // stage 2 to 3 and back
    chnlcfg_t cfg;
    logic     go;
    logic     seg_bad;
    logic     busy;

    scedma_sfr sfr_i (
        .clk, .reset, .wr, .rd, .addr, .wdata, .busy, .seg_bad,
        .rdata, .start, .op, .rpsegid, .wpsegid,
        .rpstart, .wpstart, .transize, .mask, .err
    );

    scedma_segmap segmap_i (
        .clk, .reset, .start, .op, .rpsegid, .wpsegid,
        .rpstart, .wpstart, .transize, .mask,
        .cfg, .go, .seg_bad
    );

    // done doubles as the interrupt
    scedma_chnl chnl_i (
        .clk, .reset, .cfg, .go, .rpres,
        .rpreq, .wpreq, .busy, .done (intr)
    );

endmodule

/* src/scedma_chnl.sv */
// scedma channel engine
// issues back to back reads from the read segment and writes each
// returned word, transformed by the operation, to the write segment.
// fill runs the write side alone

`timescale 1ns/1ps

module scedma_chnl
    import scedma_pkg::*, scedma_sfr_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  chnlcfg_t cfg,
    input  logic     go,
    input  chnlres_t rpres,
    output chnlreq_t rpreq,
    output chnlreq_t wpreq,
    output logic     busy,
    output logic     done
);

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DRAIN
    } state_e;

    state_e state;
    // reads issued so far
    tcnt_t  rcnt;
    // writes issued so far
    tcnt_t  wcnt;
    logic   fill;
    logic   wfire;
    logic   wlast;

    assign fill = (cfg.op == OP_FILL);
    assign busy = (state != IDLE);

    // fill writes every cycle, copy and xor write on returned data
    assign wfire = (state != IDLE) && (fill || rpres.valid);
    assign wlast = (wcnt == cfg.transsize - 1'b1);

    // write stage, no register so it lines up with the response
    always_comb begin
        wpreq       = CHNLREQ_NULL;
        wpreq.valid = wfire;
        wpreq.addr  = seg_addr(cfg.wpsegcfg, cfg.wpptr_start + wcnt);
        case (cfg.op)
            OP_XOR:  wpreq.wdata = rpres.rdata ^ cfg.mask;
            OP_FILL: wpreq.wdata = cfg.mask;
            default: wpreq.wdata = rpres.rdata;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
            rpreq <= CHNLREQ_NULL;
            rcnt  <= '0;
            wcnt  <= '0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                IDLE: begin
                    if (go) begin
                        rcnt <= tcnt_t'(1);
                        wcnt <= '0;
                        if (cfg.transsize == '0) begin
                            // empty transfer, just the interrupt
                            done <= 1'b1;
                        end else begin
                            state <= RUN;
                            // word 0 read goes out next cycle
                            if (!fill) begin
                                rpreq.valid <= 1'b1;
                                rpreq.addr  <= seg_addr(cfg.rpsegcfg, cfg.rpptr_start);
                            end
                        end
                    end
                end
                RUN: begin
                    if (!fill) begin
                        if (rcnt == cfg.transsize) begin
                            // all reads out, wait for the tail
                            rpreq.valid <= 1'b0;
                            state       <= DRAIN;
                        end else begin
                            rpreq.addr <= seg_addr(cfg.rpsegcfg, cfg.rpptr_start + rcnt);
                            rcnt       <= rcnt + 1'b1;
                        end
                    end
                end
                DRAIN: ;
                default: state <= IDLE;
            endcase
            // write counter and end of transfer
            if (wfire) begin
                wcnt <= wcnt + 1'b1;
                if (wlast) begin
                    state <= IDLE;
                    done  <= 1'b1;
                end
            end
        end
    end

endmodule

/* src/scedma_segmap.sv */
// scedma segment resolve stage
// checks both segment ids, looks them up in the segment table and
// registers the channel configuration with a go pulse

`timescale 1ns/1ps

module scedma_segmap
    import scedma_pkg::*, scedma_sfr_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     start,
    input  chnl_op_e op,
    input  segid_t   rpsegid,
    input  segid_t   wpsegid,
    input  tcnt_t    rpstart,
    input  tcnt_t    wpstart,
    input  tcnt_t    transize,
    input  dat_t     mask,
    output chnlcfg_t cfg,
    output logic     go,
    output logic     seg_bad
);

    logic    ids_ok;
    segcfg_t rpseg;
    segcfg_t wpseg;

    // both ids must hit the table
    assign ids_ok = (rpsegid < segid_t'(SEGCNT)) && (wpsegid < segid_t'(SEGCNT));

    // table lookup, low bits only
    assign rpseg = SEGCFGS[rpsegid[SEGIDW-1:0]];
    assign wpseg = SEGCFGS[wpsegid[SEGIDW-1:0]];

    always_ff @(posedge clk) begin
        if (reset) begin
            go      <= 1'b0;
            seg_bad <= 1'b0;
        end else begin
            go      <= start && ids_ok;
            seg_bad <= start && !ids_ok;
        end
    end

    // config held until the next good start
    always_ff @(posedge clk) begin
        if (start && ids_ok) begin
            cfg.rpsegcfg    <= rpseg;
            cfg.wpsegcfg    <= wpseg;
            cfg.rpptr_start <= rpstart;
            cfg.wpptr_start <= wpstart;
            cfg.transsize   <= transize;
            cfg.op          <= op;
            cfg.mask        <= mask;
        end
    end

endmodule

/* src/scedma_sfr.sv */
// scedma register bank
// holds the channel settings, turns a START key write into a
// one-cycle start pulse and returns registered read data with
// live busy and the sticky error flags

`timescale 1ns/1ps

module scedma_sfr
    import scedma_pkg::*, scedma_sfr_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     wr,
    input  logic     rd,
    input  sfr_adr_t addr,
    input  dat_t     wdata,
    input  logic     busy,
    input  logic     seg_bad,
    output dat_t     rdata,
    output logic     start,
    output chnl_op_e op,
    output segid_t   rpsegid,
    output segid_t   wpsegid,
    output tcnt_t    rpstart,
    output tcnt_t    wpstart,
    output tcnt_t    transize,
    output dat_t     mask,
    output logic [1:0] err
);

    logic start_hit;
    dat_t status;

    // key written to START
    assign start_hit = wr && (addr == A_START) && (wdata == dat_t'(START_KEY));

    // err[0] is err_busy, err[1] is err_seg
    always_comb begin
        status = '0;
        status[ST_BUSY] = busy;
        status[ST_ERRBUSY] = err[0];
        status[ST_ERRSEG] = err[1];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            start <= 1'b0;
            err   <= '0;
        end else begin
            // no restart while the channel runs
            start <= start_hit && !busy;
            // any STATUS write clears, new errors win
            if (wr && addr == A_STATUS)
                err <= '0;
            if (start_hit && busy)
                err[0] <= 1'b1;
            if (seg_bad)
                err[1] <= 1'b1;
        end
    end

    // setting registers
    always_ff @(posedge clk) begin
        if (reset) begin
            op       <= OP_COPY;
            rpsegid  <= '0;
            wpsegid  <= '0;
            rpstart  <= '0;
            wpstart  <= '0;
            transize <= '0;
            mask     <= '0;
        end else if (wr) begin
            case (addr)
                A_OPT:      op <= chnl_op_e'(wdata[1:0]);
                A_SEGID: begin
                    rpsegid <= wdata[15:8];
                    wpsegid <= wdata[7:0];
                end
                A_RPSTART:  rpstart  <= wdata[TRANSCNTW-1:0];
                A_WPSTART:  wpstart  <= wdata[TRANSCNTW-1:0];
                A_TRANSIZE: transize <= wdata[TRANSCNTW-1:0];
                A_MASK:     mask     <= wdata;
                default: ;
            endcase
        end
    end

    // read data one cycle after rd, START and holes read zero
    always_ff @(posedge clk) begin
        if (rd) begin
            case (addr)
                A_OPT:      rdata <= dat_t'(op);
                A_SEGID:    rdata <= dat_t'({rpsegid, wpsegid});
                A_RPSTART:  rdata <= dat_t'(rpstart);
                A_WPSTART:  rdata <= dat_t'(wpstart);
                A_TRANSIZE: rdata <= dat_t'(transize);
                A_MASK:     rdata <= mask;
                A_STATUS:   rdata <= status;
                default:    rdata <= '0;
            endcase
        end
    end

endmodule

/* src/scedma_pkg.sv */
// scedma datapath definitions
// sizes, vector types, the fixed segment table and the
// request/response structs of the segment memory ports

package scedma_pkg;
    import scedma_sfr_pkg::*;

    // sizes
    localparam int AW        = 12;
    localparam int DW        = 32;
    localparam int TRANSCNTW = 10;
    localparam int SEGCNT    = 4;
    // bits needed to index the segment table
    localparam int SEGIDW    = $clog2(SEGCNT);

    // word address, data word, length or pointer, segment id
    typedef logic [AW-1:0]        adr_t;
    typedef logic [DW-1:0]        dat_t;
    typedef logic [TRANSCNTW-1:0] tcnt_t;
    // wider than the table needs so a bad id shows up
    typedef logic [7:0]           segid_t;

    // one segment, size is a power of two
    typedef struct packed {
        adr_t  base;
        // size minus one
        tcnt_t sizemask;
    } segcfg_t;

    // fixed segment table
    localparam segcfg_t [0:SEGCNT-1] SEGCFGS = '{
        '{base: 12'h000, sizemask: 10'd255},
        '{base: 12'h100, sizemask: 10'd255},
        '{base: 12'h200, sizemask: 10'd127},
        '{base: 12'h280, sizemask: 10'd63}
    };

    // memory port request, also used for writes
    typedef struct packed {
        logic valid;
        adr_t addr;
        dat_t wdata;
    } chnlreq_t;

    // read response
    typedef struct packed {
        logic valid;
        dat_t rdata;
    } chnlres_t;

    // resolved channel configuration
    typedef struct packed {
        segcfg_t  rpsegcfg;
        segcfg_t  wpsegcfg;
        tcnt_t    rpptr_start;
        tcnt_t    wpptr_start;
        tcnt_t    transsize;
        chnl_op_e op;
        dat_t     mask;
    } chnlcfg_t;

    localparam chnlreq_t CHNLREQ_NULL = '{valid: 1'b0, addr: '0, wdata: '0};

    // pointer wraps inside its segment
    function automatic adr_t seg_addr(segcfg_t seg, tcnt_t ptr);
        return seg.base + adr_t'(ptr & seg.sizemask);
    endfunction

endpackage

/* src/scedma_sfr_pkg.sv */
// scedma register map
// register addresses, start key, channel operation codes and
// status bit positions seen by software on the register port

package scedma_sfr_pkg;

    // register port address
    typedef logic [7:0] sfr_adr_t;

    // register addresses
    localparam sfr_adr_t A_START    = 8'h00;
    localparam sfr_adr_t A_OPT      = 8'h04;
    localparam sfr_adr_t A_SEGID    = 8'h08;
    localparam sfr_adr_t A_RPSTART  = 8'h0c;
    localparam sfr_adr_t A_WPSTART  = 8'h10;
    localparam sfr_adr_t A_TRANSIZE = 8'h14;
    localparam sfr_adr_t A_MASK     = 8'h18;
    localparam sfr_adr_t A_STATUS   = 8'h1c;

    // only this value at START kicks the channel
    localparam logic [7:0] START_KEY = 8'h5a;

    // channel operations
    typedef enum logic [1:0] {
        OP_COPY = 2'd0,
        OP_XOR  = 2'd1,
        OP_FILL = 2'd2
    } chnl_op_e;

    // status register bits
    localparam int ST_BUSY    = 0;
    localparam int ST_ERRBUSY = 1;
    localparam int ST_ERRSEG  = 2;

endpackage
